// File: gb_timer.f
+incdir+logic
logic/timer_pkg.sv
logic/timer_div_counter.sv
logic/timer_tima_counter.sv
logic/timer_irq_regs.sv
logic/timer_bus_ctrl.sv
logic/gb_timer_top.sv
tests/tb_gb_timer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_gb_timer
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" \
  --Mdir "$OBJ_DIR" -o "$TOP" -f gb_timer.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log
if grep -q "TEST RESULT: PASS" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// File: tests/tb_gb_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_defines.svh"

module tb_gb_timer
  import timer_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  // Worst case per test: registers, DIV, rates, overflow, writes
  localparam int RUN_CYCLES = 200 + 4 * 1300 + 4 * 4900 + 2100 + 300 + 300;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 2000;

  logic     clk;
  logic     reset;
  bus_req_t bus;
  byte_t    rdata;
  logic     irq;
  int       error_count;

  // Reference model, stepped on the same edges as the DUT
  div_t      m_div;
  logic      m_tap_prev;
  byte_t     m_tima;
  logic      m_reload;
  logic      m_req;
  tac_t      m_tac;
  byte_t     m_tma;
  irq_bits_t m_if;
  irq_bits_t m_ie;

  gb_timer_top UUT (
    .clk   (clk),
    .reset (reset),
    .bus   (bus),
    .rdata (rdata),
    .irq   (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic bus_req_t make_req(addr_t addr, byte_t data, logic rd, logic wr);
    bus_req_t req;
    req.addr     = addr;
    req.wdata    = data;
    req.read_en  = rd;
    req.write_en = wr;
    return req;
  endfunction

  // Divider bit watched for each rate select
  function automatic logic tap_bit(div_t div, logic [1:0] rate);
    case (rate)
      2'b00:   return div[9];
      2'b01:   return div[3];
      2'b10:   return div[5];
      default: return div[7];
    endcase
  endfunction

  // True when the cycle after the next edge carries a tick
  function automatic logic tick_ahead();
    return tap_bit(m_div, m_tac[1:0]) & ~tap_bit(m_div + 16'h0001, m_tac[1:0]);
  endfunction

  function automatic byte_t rand_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  // Read data predicted from the model, open bits as ones
  function automatic byte_t model_read(addr_t addr);
    case (addr)
      `TIMER_ADDR_DIV:  return m_div[15:8];
      `TIMER_ADDR_TIMA: return m_tima;
      `TIMER_ADDR_TMA:  return m_tma;
      `TIMER_ADDR_TAC:  return {5'b11111, m_tac};
      `TIMER_ADDR_IF:   return {3'b111, m_if};
      `TIMER_ADDR_IE:   return {3'b000, m_ie};
      default:          return `OPEN_BUS;
    endcase
  endfunction

  // One step per edge from the request of the ending cycle
  always @(posedge clk) begin : model_step
    logic      cur_tap;
    logic      cur_tick;
    logic      wr;
    irq_bits_t next_if;
    cur_tap  = tap_bit(m_div, m_tac[1:0]);
    cur_tick = m_tap_prev & ~cur_tap;
    wr       = bus.write_en;
    next_if  = (wr && bus.addr == `TIMER_ADDR_IF) ? bus.wdata[4:0] : m_if;
    if (reset) begin
      m_div      <= '0;
      m_tap_prev <= 1'b0;
      m_tima     <= '0;
      m_reload   <= 1'b0;
      m_req      <= 1'b0;
      m_tac      <= '0;
      m_tma      <= '0;
      m_if       <= '0;
      m_ie       <= '0;
    end else begin
      m_div      <= (wr && bus.addr == `TIMER_ADDR_DIV) ? 16'h0000 : m_div + 16'h0001;
      m_tap_prev <= cur_tap;
      m_reload   <= 1'b0;
      m_req      <= m_reload;
      // Reload first, then CPU write, then tick
      if (m_reload) begin
        m_tima <= m_tma;
      end else if (wr && bus.addr == `TIMER_ADDR_TIMA) begin
        m_tima <= bus.wdata;
      end else if (cur_tick && m_tac[2]) begin
        m_tima   <= m_tima + 8'h01;
        m_reload <= (m_tima == 8'hFF);
      end
      // Request beats an IF write
      if (m_req) begin
        next_if[`IF_TIMER_BIT] = 1'b1;
      end
      m_if <= next_if;
      if (wr && bus.addr == `TIMER_ADDR_IE) begin
        m_ie <= bus.wdata[4:0];
      end
      if (wr && bus.addr == `TIMER_ADDR_TMA) begin
        m_tma <= bus.wdata;
      end
      if (wr && bus.addr == `TIMER_ADDR_TAC) begin
        m_tac <= bus.wdata[2:0];
      end
    end
  end

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_byte(byte_t actual, byte_t expected, string what);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at time %0t: %s, expected %02h, got %02h",
               $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(logic actual, logic expected, string what);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at time %0t: %s, expected %b, got %b",
               $time, what, expected, actual);
      abort_run();
    end
  endtask

  // Write is taken at the edge after the driving edge
  task automatic bus_write(addr_t addr, byte_t data);
    @(posedge clk);
    bus <= make_req(addr, data, 1'b0, 1'b1);
    @(posedge clk);
    bus <= '0;
  endtask

  // Sampled mid-cycle, always checked against the model
  task automatic bus_read(addr_t addr, string what, output byte_t data);
    @(posedge clk);
    bus <= make_req(addr, 8'h00, 1'b1, 1'b0);
    @(negedge clk);
    data = rdata;
    check_byte(data, model_read(addr), what);
  endtask

  task automatic read_expect(addr_t addr, byte_t expected, string what);
    byte_t data;
    bus_read(addr, what, data);
    check_byte(data, expected, what);
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk);
      bus <= '0;
    end
  endtask

  task automatic test_reset_values();
    read_expect(`TIMER_ADDR_DIV, 8'h00, "DIV after reset");
    read_expect(`TIMER_ADDR_TIMA, 8'h00, "TIMA after reset");
    read_expect(`TIMER_ADDR_TMA, 8'h00, "TMA after reset");
    read_expect(`TIMER_ADDR_TAC, 8'hF8, "TAC after reset");
    read_expect(`TIMER_ADDR_IF, 8'hE0, "IF after reset");
    read_expect(`TIMER_ADDR_IE, 8'h00, "IE after reset");
    bus_write(`TIMER_ADDR_TAC, 8'hFF);
    read_expect(`TIMER_ADDR_TAC, 8'hF8 | (8'hFF & `TAC_MASK), "TAC after FF");
    bus_write(`TIMER_ADDR_TAC, 8'h00);
    bus_write(`TIMER_ADDR_IF, 8'hFF);
    read_expect(`TIMER_ADDR_IF, 8'hFF, "IF after FF");
    check_bit(irq, 1'b0, "irq with IE clear");
    bus_write(`TIMER_ADDR_IF, 8'h00);
    read_expect(16'hFF10, `OPEN_BUS, "unmapped FF10");
    read_expect(16'h0000, `OPEN_BUS, "unmapped 0000");
    // Selected address but read_en low
    @(posedge clk);
    bus <= make_req(`TIMER_ADDR_IE, 8'h00, 1'b0, 1'b0);
    @(negedge clk);
    check_byte(rdata, `OPEN_BUS, "read with read_en low");
  endtask

  task automatic test_div_clear();
    logic [31:0] k;
    repeat (4) begin
      k = 32'd256 + ($urandom % 32'd1024);
      bus_write(`TIMER_ADDR_DIV, rand_byte());
      // Read lands k edges after the clearing edge
      idle_cycles(k - 1);
      read_expect(`TIMER_ADDR_DIV, k[15:8], "DIV k cycles after clear");
    end
  endtask

  task automatic test_rates();
    logic [2:0] rate;
    byte_t      tac_val;
    byte_t      data;
    byte_t      held;
    for (rate = 3'd0; rate < 3'd4; rate++) begin
      // Random unused bits, enable set
      tac_val                  = rand_byte();
      tac_val[`TAC_ENABLE_BIT] = 1'b1;
      tac_val[1:0]             = rate[1:0];
      bus_write(`TIMER_ADDR_TAC, tac_val);
      bus_write(`TIMER_ADDR_TIMA, rand_byte());
      repeat (3) begin
        idle_cycles(64 + ($urandom % 1500));
        bus_read(`TIMER_ADDR_TIMA, "TIMA while counting", data);
      end
    end
    // Disabled timer holds its count
    tac_val                  = rand_byte();
    tac_val[`TAC_ENABLE_BIT] = 1'b0;
    bus_write(`TIMER_ADDR_TAC, tac_val);
    bus_read(`TIMER_ADDR_TIMA, "TIMA after disable", held);
    idle_cycles(2000);
    read_expect(`TIMER_ADDR_TIMA, held, "TIMA with timer disabled");
  endtask

  task automatic test_overflow();
    byte_t tma_val;
    byte_t data;
    int    tries;
    for (int ie_on = 0; ie_on < 2; ie_on++) begin
      // Below FF so the next wrap is two ticks away
      tma_val = rand_byte() % 8'hFF;
      bus_write(`TIMER_ADDR_TAC, 8'h00);
      bus_write(`TIMER_ADDR_TMA, tma_val);
      bus_write(`TIMER_ADDR_IE, (ie_on != 0) ? 8'h04 : 8'h1B);
      bus_write(`TIMER_ADDR_IF, 8'h00);
      bus_write(`TIMER_ADDR_TIMA, 8'hFF);
      bus_write(`TIMER_ADDR_TAC, 8'h05);
      // Poll each cycle until the wrap shows
      tries = 0;
      data  = 8'hFF;
      while (data == 8'hFF && tries < 64) begin
        bus_read(`TIMER_ADDR_TIMA, "TIMA before wrap", data);
        tries++;
      end
      if (data == 8'hFF) begin
        $display("TIMA never overflowed with the timer enabled");
        abort_run();
      end
      check_byte(data, 8'h00, "TIMA in the reload cycle");
      read_expect(`TIMER_ADDR_TIMA, tma_val, "TIMA reloaded from TMA");
      check_bit(irq, 1'b0, "irq before the flag is set");
      read_expect(`TIMER_ADDR_IF, 8'hE4, "IF timer flag after overflow");
      check_bit(irq, ie_on[0], "irq against IE bit 2");
    end
  endtask

  task automatic test_ack_and_write();
    byte_t value;
    byte_t data;
    int    tries;
    check_bit(irq, 1'b1, "irq before acknowledge");
    bus_write(`TIMER_ADDR_IF, 8'h00);
    @(negedge clk);
    check_bit(irq, 1'b0, "irq after IF cleared");
    bus_write(`TIMER_ADDR_TIMA, 8'h10);
    repeat (3) begin
      value = rand_byte();
      tries = 0;
      @(negedge clk);
      while (!tick_ahead() && tries < 64) begin
        @(negedge clk);
        tries++;
      end
      if (tries >= 64) begin
        $display("no timer tick found to collide with a TIMA write");
        abort_run();
      end
      // Write lands on the tick edge
      bus_write(`TIMER_ADDR_TIMA, value);
      read_expect(`TIMER_ADDR_TIMA, value, "TIMA write over a tick");
      idle_cycles(5 + ($urandom % 40));
      bus_read(`TIMER_ADDR_TIMA, "TIMA after the write", data);
    end
  endtask

  initial begin
    void'($urandom(32'ha144_5455));
    error_count = 0;
    clk         = 1'b0;
    reset       = 1'b1;
    bus         = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_reset_values();
    test_div_clear();
    test_rates();
    test_overflow();
    test_ack_and_write();
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

`default_nettype wire

// File: logic/gb_timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module gb_timer_top
  import timer_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire bus_req_t bus,
  output byte_t         rdata,
  output logic          irq
);

  // Control levels
  tac_t  tac;
  byte_t tma;
  byte_t wdata;

  // Write strobes
  logic div_clear;
  logic tima_wr;
  logic if_wr;
  logic ie_wr;

  // Datapath results
  byte_t     div_high;
  byte_t     tima;
  logic      tick;
  logic      timer_req;
  irq_bits_t if_bits;
  irq_bits_t ie_bits;

  timer_bus_ctrl u_bus_ctrl (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .div_high  (div_high),
    .tima      (tima),
    .if_bits   (if_bits),
    .ie_bits   (ie_bits),
    .rdata     (rdata),
    .tac       (tac),
    .tma       (tma),
    .div_clear (div_clear),
    .tima_wr   (tima_wr),
    .if_wr     (if_wr),
    .ie_wr     (ie_wr),
    .wdata     (wdata)
  );

  timer_div_counter u_div (
    .clk       (clk),
    .reset     (reset),
    .div_clear (div_clear),
    .tac       (tac),
    .div_high  (div_high),
    .tick      (tick)
  );

  timer_tima_counter u_tima (
    .clk       (clk),
    .reset     (reset),
    .tick      (tick),
    .tac       (tac),
    .tma       (tma),
    .tima_wr   (tima_wr),
    .wdata     (wdata),
    .tima      (tima),
    .timer_req (timer_req)
  );

  timer_irq_regs u_irq (
    .clk       (clk),
    .reset     (reset),
    .timer_req (timer_req),
    .if_wr     (if_wr),
    .ie_wr     (ie_wr),
    .wdata     (wdata),
    .if_bits   (if_bits),
    .ie_bits   (ie_bits),
    .irq       (irq)
  );

endmodule

`default_nettype wire

// File: logic/timer_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_defines.svh"

module timer_bus_ctrl
  import timer_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire bus_req_t  bus,
  input  wire byte_t     div_high,
  input  wire byte_t     tima,
  input  wire irq_bits_t if_bits,
  input  wire irq_bits_t ie_bits,
  output byte_t          rdata,
  output tac_t           tac,
  output byte_t          tma,
  output logic           div_clear,
  output logic           tima_wr,
  output logic           if_wr,
  output logic           ie_wr,
  output byte_t          wdata
);

  logic  sel_div;
  logic  sel_tima;
  logic  sel_tma;
  logic  sel_tac;
  logic  sel_if;
  logic  sel_ie;
  byte_t tma_q;
  tac_t  tac_q;
  byte_t tac_masked;

  // Address decode
  assign sel_div  = (bus.addr == `TIMER_ADDR_DIV);
  assign sel_tima = (bus.addr == `TIMER_ADDR_TIMA);
  assign sel_tma  = (bus.addr == `TIMER_ADDR_TMA);
  assign sel_tac  = (bus.addr == `TIMER_ADDR_TAC);
  assign sel_if   = (bus.addr == `TIMER_ADDR_IF);
  assign sel_ie   = (bus.addr == `TIMER_ADDR_IE);

  // Only three TAC bits exist
  assign tac_masked = bus.wdata & `TAC_MASK;

  // TMA and TAC live here
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tma_q <= `REG_RESET;
      tac_q <= '0;
    end else if (bus.write_en) begin
      if (sel_tma) begin
        tma_q <= bus.wdata;
      end
      if (sel_tac) begin
        tac_q <= tac_masked[2:0];
      end
    end
  end

  assign tma = tma_q;
  assign tac = tac_q;

  // Write strobes to the datapath, same cycle as the bus write
  assign div_clear = bus.write_en & sel_div;
  assign tima_wr   = bus.write_en & sel_tima;
  assign if_wr     = bus.write_en & sel_if;
  assign ie_wr     = bus.write_en & sel_ie;
  assign wdata     = bus.wdata;

  // Combinational read, open bus when idle or unmapped
  always_comb begin
    rdata = `OPEN_BUS;
    if (bus.read_en) begin
      if (sel_div) begin
        rdata = div_high;
      end else if (sel_tima) begin
        rdata = tima;
      end else if (sel_tma) begin
        rdata = tma_q;
      end else if (sel_tac) begin
        // Unused high bits read as ones
        rdata = ~`TAC_MASK | {5'b00000, tac_q};
      end else if (sel_if) begin
        rdata = ~`IF_MASK | {3'b000, if_bits};
      end else if (sel_ie) begin
        rdata = {3'b000, ie_bits};
      end
    end
  end

  // Bus never reads and writes together
  a_no_rd_wr: assert property (
    @(posedge clk) disable iff (reset)
    !(bus.read_en && bus.write_en)
  ) else $error("read_en and write_en high in the same cycle");

endmodule

`default_nettype wire

// File: logic/timer_irq_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_defines.svh"

module timer_irq_regs
  import timer_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  timer_req,
  input  wire logic  if_wr,
  input  wire logic  ie_wr,
  input  wire byte_t wdata,
  output irq_bits_t  if_bits,
  output irq_bits_t  ie_bits,
  output logic       irq
);

  irq_bits_t if_q;
  irq_bits_t ie_q;

  // Interrupt flags
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_q <= '0;
    end else begin
      // CPU writes or acknowledges flags
      if (if_wr) begin
        if_q <= wdata[4:0];
      end
      // Timer request wins over a same-cycle write
      if (timer_req) begin
        if_q[`IF_TIMER_BIT] <= 1'b1;
      end
    end
  end

  // Interrupt enables, plain storage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ie_q <= '0;
    end else if (ie_wr) begin
      ie_q <= wdata[4:0];
    end
  end

  assign if_bits = if_q;
  assign ie_bits = ie_q;

  // Level stays up until the flag is cleared or disabled
  assign irq = |(if_q & ie_q);

endmodule

`default_nettype wire

// File: logic/timer_tima_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_defines.svh"

module timer_tima_counter
  import timer_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  tick,
  input  wire tac_t  tac,
  input  wire byte_t tma,
  input  wire logic  tima_wr,
  input  wire byte_t wdata,
  output byte_t      tima,
  output logic       timer_req
);

  tima_state_t state;
  byte_t       tima_q;
  logic        count_en;

  // Increment only when the timer is enabled
  assign count_en = tick & tac[`TAC_ENABLE_BIT];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= TIMA_COUNT;
      tima_q    <= `REG_RESET;
      timer_req <= 1'b0;
    end else begin
      // Request is a single-cycle pulse
      timer_req <= 1'b0;
      unique case (state)
        TIMA_RELOAD: begin
          // Reload beats a CPU write in this cycle
          tima_q    <= tma;
          timer_req <= 1'b1;
          state     <= TIMA_COUNT;
        end
        TIMA_COUNT: begin
          if (tima_wr) begin
            // CPU write overrides the increment
            tima_q <= wdata;
          end else if (count_en) begin
            if (tima_q == 8'hFF) begin
              // Wrap to 00 and hold there for one cycle
              tima_q <= 8'h00;
              state  <= TIMA_RELOAD;
            end else begin
              tima_q <= tima_q + 8'h01;
            end
          end
        end
      endcase
    end
  end

  assign tima = tima_q;

  // Request only follows a reload cycle
  a_req_after_reload: assert property (
    @(posedge clk) disable iff (reset)
    timer_req |-> $past(state) == TIMA_RELOAD
  ) else $error("timer_req without a preceding reload cycle");

  // Reload lasts exactly one cycle
  a_reload_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    state == TIMA_RELOAD |=> state == TIMA_COUNT
  ) else $error("TIMA stayed in reload for two cycles");

endmodule

`default_nettype wire

// File: logic/timer_div_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "timer_defines.svh"

module timer_div_counter
  import timer_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  div_clear,
  input  wire tac_t  tac,
  output byte_t      div_high,
  output logic       tick
);

  div_t div_q;
  logic tap;
  logic tap_prev;

  // Counts every clock, a DIV write restarts from zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_q <= `DIV_RESET;
    end else if (div_clear) begin
      div_q <= `DIV_RESET;
    end else begin
      div_q <= div_q + 16'd1;
    end
  end

  // Tap chosen by the TAC rate select
  always_comb begin
    unique case (tac[`TAC_RATE_HI:`TAC_RATE_LO])
      2'b00: tap = div_q[9];
      2'b01: tap = div_q[3];
      2'b10: tap = div_q[5];
      2'b11: tap = div_q[7];
    endcase
  end

  // Tap value seen at the previous edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tap_prev <= 1'b0;
    end else begin
      tap_prev <= tap;
    end
  end

  // Falling edge of the tap, a DIV clear can cause one too
  assign tick = tap_prev & ~tap;

  // CPU only sees the upper byte
  assign div_high = div_q[15:8];

endmodule

`default_nettype wire

// File: logic/timer_pkg.sv
`default_nettype none

package timer_pkg;

  // Bus address and data widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // Internal divider, only the upper byte is visible
  typedef logic [15:0] div_t;

  // Enable in bit 2, rate select in bits 1:0
  typedef logic [2:0] tac_t;

  // VBlank, STAT, timer, serial, joypad
  typedef logic [4:0] irq_bits_t;

  // One bus request per cycle
  typedef struct packed {
    addr_t addr;
    byte_t wdata;
    logic  read_en;
    logic  write_en;
  } bus_req_t;

  // TIMA overflow handling
  typedef enum logic {
    TIMA_COUNT  = 1'b0,
    TIMA_RELOAD = 1'b1
  } tima_state_t;

endpackage

`default_nettype wire

// File: logic/timer_defines.svh
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// Register addresses on the I/O bus
`define TIMER_ADDR_DIV  16'hFF04
`define TIMER_ADDR_TIMA 16'hFF05
`define TIMER_ADDR_TMA  16'hFF06
`define TIMER_ADDR_TAC  16'hFF07
`define TIMER_ADDR_IF   16'hFF0F
`define TIMER_ADDR_IE   16'hFFFF

// TAC fields
`define TAC_MASK       8'h07
`define TAC_ENABLE_BIT 2
`define TAC_RATE_HI    1
`define TAC_RATE_LO    0

// IF and IE fields, timer is source 2
`define IF_MASK      8'h1F
`define IF_TIMER_BIT 2

// Reset and idle bus values
`define DIV_RESET  16'h0000
`define REG_RESET  8'h00
`define OPEN_BUS   8'hFF

`endif
